//--- Bender.yml
package:
  name: cl_shell_glue

dependencies: {}

sources:
  # RTL in compile order
  - shell_glue_pkg.sv
  - lib_pipe.sv
  - rst_sync_tree.sv
  - flr_ready_monitor.sv
  - ddr_stat_bridge.sv
  - cl_shell_top.sv
  # Testbench, top module tb_cl_shell_top
  - target: test
    files:
      - tb_cl_shell_top.sv

//--- cl_shell_top.sv
/*
 * Top of the shell glue between the FPGA shell and the user design.
 * Joins reset distribution, FLR and DDR ready handling and the
 * statistics transport, and adapts AXI IDs between the 6-bit host
 * side and the 16-bit core side.
 */
`timescale 1ns/1ps

module cl_shell_top
   import shell_glue_pkg::*;
(
   input  logic                   clk_main_a0,
   input  logic                   sync_rst_n,       // Shell reset, async

   // Reset branches
   output logic                   ddr_rst_n,        // Memory controller
   output logic                   core_rst_n,       // User core

   // FLR handshake
   input  logic                   flr_assert,
   output logic                   flr_done,

   // DDR ready
   input  logic [NUM_STAT_CH-1:0] ctrl_ready,       // A, B, D
   input  logic                   ddr_c_ready,      // C
   output logic [NUM_DDR-1:0]     ddr_ready,

   // Statistics channels
   input  stat_req_t              stat_req_in  [NUM_STAT_CH],
   output stat_req_t              stat_req_out [NUM_STAT_CH],
   input  stat_rsp_t              stat_rsp_in  [NUM_STAT_CH],
   output stat_rsp_t              stat_rsp_out [NUM_STAT_CH],

   // Host side AXI IDs
   input  logic [HOST_ID_W-1:0]   host_awid,
   input  logic [HOST_ID_W-1:0]   host_arid,
   output logic [HOST_ID_W-1:0]   host_bid,
   output logic [HOST_ID_W-1:0]   host_rid,

   // Core side AXI IDs
   output logic [CORE_ID_W-1:0]   core_awid,
   output logic [CORE_ID_W-1:0]   core_arid,
   input  logic [CORE_ID_W-1:0]   core_bid,
   input  logic [CORE_ID_W-1:0]   core_rid
);

   logic local_rst_n;     // Synchronized reset for the glue blocks

   // ------------------------------------------------------------------------
   // Reset distribution

   rst_sync_tree rst_tree (
      .clk_main_a0 (clk_main_a0),
      .sync_rst_n  (sync_rst_n),
      .local_rst_n (local_rst_n),
      .ddr_rst_n   (ddr_rst_n),
      .core_rst_n  (core_rst_n)
   );

   // ------------------------------------------------------------------------
   // FLR and DDR ready

   flr_ready_monitor status_mon (
      .clk_main_a0 (clk_main_a0),
      .local_rst_n (local_rst_n),
      .flr_assert  (flr_assert),
      .flr_done    (flr_done),
      .ctrl_ready  (ctrl_ready),
      .ddr_c_ready (ddr_c_ready),
      .ddr_ready   (ddr_ready)
   );

   // ------------------------------------------------------------------------
   // Statistics transport

   ddr_stat_bridge stat_bridge (
      .clk_main_a0  (clk_main_a0),
      .local_rst_n  (local_rst_n),
      .stat_req_in  (stat_req_in),
      .stat_req_out (stat_req_out),
      .stat_rsp_in  (stat_rsp_in),
      .stat_rsp_out (stat_rsp_out)
   );

   // ------------------------------------------------------------------------
   // AXI ID width adaptation

   // Host IDs widen with zero fill
   assign core_awid = {{ID_PAD_W{1'b0}}, host_awid};
   assign core_arid = {{ID_PAD_W{1'b0}}, host_arid};

   // Core echoes the padded ID so upper bits carry nothing
   assign host_bid  = core_bid[HOST_ID_W-1:0];
   assign host_rid  = core_rid[HOST_ID_W-1:0];

endmodule

//--- ddr_stat_bridge.sv
/*
 * Statistics transport between the shell and the memory controller.
 * Each channel gets a request pipe toward the controller and a
 * response pipe back to the shell, STAT_PIPE_STAGES deep each way.
 * No back-pressure exists on this bus so the pipes never stall.
 */
`timescale 1ns/1ps

module ddr_stat_bridge
   import shell_glue_pkg::*;
(
   input  logic      clk_main_a0,
   input  logic      local_rst_n,

   // Shell side requests and controller side copies
   input  stat_req_t stat_req_in  [NUM_STAT_CH],
   output stat_req_t stat_req_out [NUM_STAT_CH],

   // Controller side responses and shell side copies
   input  stat_rsp_t stat_rsp_in  [NUM_STAT_CH],
   output stat_rsp_t stat_rsp_out [NUM_STAT_CH]
);

   localparam int REQ_W = $bits(stat_req_t);   // 42
   localparam int RSP_W = $bits(stat_rsp_t);   // 41

   // ------------------------------------------------------------------------
   // Per-channel pipes

   // Index 0, 1, 2 map to DDR A, B, D
   for (genvar ch = 0; ch < NUM_STAT_CH; ch++)
   begin : g_stat_ch

      logic [REQ_W-1:0] req_flat;       // Flattened request out of the pipe
      logic [RSP_W-1:0] rsp_flat;       // Flattened response out of the pipe

      // Request path, strobes clear in reset
      lib_pipe #(
         .WIDTH  (REQ_W),
         .STAGES (STAT_PIPE_STAGES)
      ) req_pipe (
         .clk_main_a0 (clk_main_a0),
         .rst_n       (local_rst_n),
         .in_bus      (stat_req_in[ch]),
         .out_bus     (req_flat)
      );

      // Response path, ack clears in reset
      lib_pipe #(
         .WIDTH  (RSP_W),
         .STAGES (STAT_PIPE_STAGES)
      ) rsp_pipe (
         .clk_main_a0 (clk_main_a0),
         .rst_n       (local_rst_n),
         .in_bus      (stat_rsp_in[ch]),
         .out_bus     (rsp_flat)
      );

      // Back into struct form
      assign stat_req_out[ch] = stat_req_t'(req_flat);
      assign stat_rsp_out[ch] = stat_rsp_t'(rsp_flat);

   end

endmodule

//--- flr_ready_monitor.sv
/*
 * Function-level reset response and DDR ready gathering.
 * flr_done pulses back to the shell while an FLR request is held.
 * The four DDR ready flags are merged into one vector for the core,
 * with the shell's C flag retimed by one register.
 */
`timescale 1ns/1ps

module flr_ready_monitor
   import shell_glue_pkg::*;
(
   input  logic                   clk_main_a0,
   input  logic                   local_rst_n,
   input  logic                   flr_assert,     // From shell
   output logic                   flr_done,       // Back to shell
   input  logic [NUM_STAT_CH-1:0] ctrl_ready,     // A, B, D from controller
   input  logic                   ddr_c_ready,    // C from shell
   output logic [NUM_DDR-1:0]     ddr_ready
);

   logic flr_assert_q;      // Registered request
   logic ddr_c_ready_q;     // Retimed C flag

   // ------------------------------------------------------------------------
   // FLR response

   always_ff @(posedge clk_main_a0 or negedge local_rst_n)
   begin
      if (!local_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         // Never high two cycles running
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   // ------------------------------------------------------------------------
   // DDR ready vector

   always_ff @(posedge clk_main_a0 or negedge local_rst_n)
   begin
      if (!local_rst_n)
         ddr_c_ready_q <= 1'b0;
      else
         ddr_c_ready_q <= ddr_c_ready;    // One cycle behind the shell
   end

   // Controller flags pass straight through
   assign ddr_ready[DDR_A_BIT] = ctrl_ready[0];
   assign ddr_ready[DDR_B_BIT] = ctrl_ready[1];
   assign ddr_ready[DDR_C_BIT] = ddr_c_ready_q;
   assign ddr_ready[DDR_D_BIT] = ctrl_ready[2];

endmodule

//--- lib_pipe.sv
/*
 * Resettable delay line of STAGES registers.
 * Output is the input delayed by exactly STAGES clocks.
 * All stages clear asynchronously while rst_n is low.
 */
`timescale 1ns/1ps

module lib_pipe
   import shell_glue_pkg::*;
#(
   parameter int WIDTH  = 1,                 // Bus width
   parameter int STAGES = RST_PIPE_STAGES    // Depth, at least one
)
(
   input  logic             clk_main_a0,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   logic [WIDTH-1:0] pipe_q [STAGES];   // Stage 0 nearest the input

   always_ff @(posedge clk_main_a0 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            pipe_q[i] <= '0;             // Whole chain drops at once
         end
      end
      else
      begin
         pipe_q[0] <= in_bus;
         for (int i = 1; i < STAGES; i++)
         begin
            pipe_q[i] <= pipe_q[i-1];    // Shift one stage per clock
         end
      end
   end

   assign out_bus = pipe_q[STAGES-1];

endmodule

//--- rst_sync_tree.sv
/*
 * Reset synchronizer and distribution tree.
 * The shell reset asserts at once and releases after two flops.
 * Two pipelined branches then feed the memory controller and
 * the user core, each releasing RST_PIPE_STAGES clocks later.
 */
`timescale 1ns/1ps

module rst_sync_tree
   import shell_glue_pkg::*;
(
   input  logic clk_main_a0,
   input  logic sync_rst_n,     // From shell, asynchronous
   output logic local_rst_n,    // Glue logic reset
   output logic ddr_rst_n,      // To memory controller
   output logic core_rst_n      // To user core
);

   logic pre_sync_rst_n;        // First synchronizer flop

   // ------------------------------------------------------------------------
   // Synchronizer

   // Async assert, release on second edge
   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         pre_sync_rst_n <= 1'b0;
         local_rst_n    <= 1'b0;
      end
      else
      begin
         pre_sync_rst_n <= 1'b1;
         local_rst_n    <= pre_sync_rst_n;
      end
   end

   // ------------------------------------------------------------------------
   // Branches

   // Reset pin of each pipe is the local reset itself
   // so a branch drops with it and trails on release
   lib_pipe #(
      .WIDTH  (1),
      .STAGES (RST_PIPE_STAGES)
   ) ddr_rst_pipe (
      .clk_main_a0 (clk_main_a0),
      .rst_n       (local_rst_n),
      .in_bus      (local_rst_n),
      .out_bus     (ddr_rst_n)
   );

   lib_pipe #(
      .WIDTH  (1),
      .STAGES (RST_PIPE_STAGES)
   ) core_rst_pipe (
      .clk_main_a0 (clk_main_a0),
      .rst_n       (local_rst_n),
      .in_bus      (local_rst_n),
      .out_bus     (core_rst_n)
   );

endmodule

//--- shell_glue_pkg.sv
/*
 * Shared widths, depths and bus types for the shell glue logic.
 * Covers reset distribution, FLR handling, DDR ready gathering and
 * the statistics transport between shell and memory controller.
 * Modules pull these in with a wildcard import in their headers.
 */
package shell_glue_pkg;

   // ------------------------------------------------------------------------
   // DDR ready vector

   localparam int NUM_DDR   = 4;      // Channels A, B, C, D
   localparam int DDR_A_BIT = 0;
   localparam int DDR_B_BIT = 1;
   localparam int DDR_C_BIT = 2;      // Comes straight from the shell
   localparam int DDR_D_BIT = 3;

   // ------------------------------------------------------------------------
   // Pipeline depths

   // Controller stats ports serve A, B and D only
   localparam int NUM_STAT_CH      = 3;
   localparam int STAT_PIPE_STAGES = 8;   // Long route to the controller
   localparam int RST_PIPE_STAGES  = 4;   // Per reset branch

   // ------------------------------------------------------------------------
   // Statistics bus widths

   localparam int STAT_ADDR_W = 8;
   localparam int STAT_DATA_W = 32;
   localparam int STAT_INT_W  = 8;

   // AXI ID widths on either side of the glue
   localparam int HOST_ID_W = 6;
   localparam int CORE_ID_W = 16;
   localparam int ID_PAD_W  = CORE_ID_W - HOST_ID_W;   // Zero fill toward core

   // ------------------------------------------------------------------------
   // Statistics channel payloads

   // Shell to controller, one-cycle strobe
   typedef struct packed {
      logic                   wr;      // Write strobe
      logic                   rd;      // Read strobe
      logic [STAT_ADDR_W-1:0] addr;    // Register offset
      logic [STAT_DATA_W-1:0] wdata;   // Write payload
   } stat_req_t;

   // Controller to shell, one-cycle ack
   typedef struct packed {
      logic                   ack;     // Access done
      logic [STAT_INT_W-1:0]  intr;    // Interrupt bits
      logic [STAT_DATA_W-1:0] rdata;   // Read payload, valid with ack
   } stat_rsp_t;

   // 42 and 41 bits as packed

endpackage

//--- tb_cl_shell_top.sv
/*
 * Self-checking testbench for the shell glue top level.
 * Drives reset, FLR, ready flags, statistics traffic and AXI IDs,
 * keeps its own history of driven values and checks every output
 * with immediate assertions on each falling clock edge.
 */
`timescale 1ns/1ps

module tb_cl_shell_top
   import shell_glue_pkg::*;
();

   localparam int CLK_PERIOD     = 40;
   localparam int RESET_CYCLES   = 10;
   localparam int SYNC_EDGES     = 2;                              // Local reset release
   localparam int BRANCH_EDGES   = SYNC_EDGES + RST_PIPE_STAGES;   // Plus branch pipe
   localparam int TIMEOUT_CYCLES = 2000;                  // About 4x the ~450 used

   logic                   clk_main_a0;
   logic                   sync_rst_n;
   logic                   ddr_rst_n;
   logic                   core_rst_n;
   logic                   flr_assert;
   logic                   flr_done;
   logic [NUM_STAT_CH-1:0] ctrl_ready;
   logic                   ddr_c_ready;
   logic [NUM_DDR-1:0]     ddr_ready;
   stat_req_t              stat_req_in  [NUM_STAT_CH];
   stat_req_t              stat_req_out [NUM_STAT_CH];
   stat_rsp_t              stat_rsp_in  [NUM_STAT_CH];
   stat_rsp_t              stat_rsp_out [NUM_STAT_CH];
   logic [HOST_ID_W-1:0]   host_awid;
   logic [HOST_ID_W-1:0]   host_arid;
   logic [HOST_ID_W-1:0]   host_bid;
   logic [HOST_ID_W-1:0]   host_rid;
   logic [CORE_ID_W-1:0]   core_awid;
   logic [CORE_ID_W-1:0]   core_arid;
   logic [CORE_ID_W-1:0]   core_bid;
   logic [CORE_ID_W-1:0]   core_rid;

   // Reference model state
   stat_req_t   req_hist [NUM_STAT_CH][STAT_PIPE_STAGES];   // Entry 0 newest
   stat_rsp_t   rsp_hist [NUM_STAT_CH][STAT_PIPE_STAGES];
   int          rel_edges;       // Edges since sync_rst_n seen high
   int          flr_run;         // High run of flr_assert up to last edge
   int          flr_run_prev;    // flr_run one edge earlier
   logic        c_ready_prev;    // ddr_c_ready sampled at last edge
   int          cycle_cnt;
   int          check_cnt;
   int          err_cnt;
   logic [15:0] lfsr_state;

   cl_shell_top cl_shell_top_inst (.*);

   // ------------------------------------------------------------------------
   // Clock and cycle count

   initial
   begin
      clk_main_a0 = 1'b0;
      forever #(CLK_PERIOD/2) clk_main_a0 = ~clk_main_a0;
   end

   initial
   begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   // ------------------------------------------------------------------------
   // Random source

   // Galois taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 16'hB400;
      return n;
   endfunction

   // One step per bit handed out
   task automatic take_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v[i]       = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // ------------------------------------------------------------------------
   // Stimulus helpers called just after a rising edge

   task automatic drive_random();
      logic [63:0] v;
      stat_req_t   req;
      stat_rsp_t   rsp;
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         take_bits(2, v);
         req.wr    = v[0];
         req.rd    = v[1];
         take_bits(STAT_ADDR_W, v);
         req.addr  = v[STAT_ADDR_W-1:0];
         take_bits(STAT_DATA_W, v);
         req.wdata = v[STAT_DATA_W-1:0];
         take_bits(1 + STAT_INT_W, v);
         rsp.ack   = v[0];
         rsp.intr  = v[STAT_INT_W:1];
         take_bits(STAT_DATA_W, v);
         rsp.rdata = v[STAT_DATA_W-1:0];
         stat_req_in[ch] <= req;
         stat_rsp_in[ch] <= rsp;
      end
      take_bits(NUM_STAT_CH + 1, v);
      ctrl_ready  <= v[NUM_STAT_CH-1:0];
      ddr_c_ready <= v[NUM_STAT_CH];
      take_bits(2 * HOST_ID_W, v);
      host_awid   <= v[HOST_ID_W-1:0];
      host_arid   <= v[2*HOST_ID_W-1:HOST_ID_W];
      take_bits(2 * CORE_ID_W, v);
      core_bid    <= v[CORE_ID_W-1:0];
      core_rid    <= v[2*CORE_ID_W-1:CORE_ID_W];
   endtask

   // Quiet statistics bus and C flag around a reset
   task automatic drive_idle();
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         stat_req_in[ch] <= '0;
         stat_rsp_in[ch] <= '0;
      end
      ddr_c_ready <= 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // Reference model sampled on the same edge as the DUT

   always @(posedge clk_main_a0)
   begin
      cycle_cnt    <= cycle_cnt + 1;
      c_ready_prev <= ddr_c_ready;
      flr_run_prev <= flr_run;
      flr_run      <= flr_assert ? flr_run + 1 : 0;
      if (!sync_rst_n)
         rel_edges <= 0;
      else if (rel_edges < 255)
         rel_edges <= rel_edges + 1;      // Saturates well past any release edge
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         req_hist[ch][0] <= stat_req_in[ch];
         rsp_hist[ch][0] <= stat_rsp_in[ch];
         for (int i = 1; i < STAT_PIPE_STAGES; i++)
         begin
            req_hist[ch][i] <= req_hist[ch][i-1];
            rsp_hist[ch][i] <= rsp_hist[ch][i-1];
         end
      end
      // Local reset still low before this edge keeps every stage clear
      if (!sync_rst_n || rel_edges < SYNC_EDGES)
      begin
         for (int ch = 0; ch < NUM_STAT_CH; ch++)
         begin
            for (int i = 0; i < STAT_PIPE_STAGES; i++)
            begin
               req_hist[ch][i] <= '0;
               rsp_hist[ch][i] <= '0;
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // Checks

   task automatic check_val(input string name, input logic [63:0] exp,
                            input logic [63:0] act);
      check_cnt++;
      assert (act === exp)
      else
      begin
         err_cnt++;
         $display("ERR %s at %0t: expected %0h, actual %0h", name, $time, exp, act);
      end
   endtask

   // Outputs are settled half a cycle after the driving edge
   always @(negedge clk_main_a0)
   begin : output_checks
      logic               exp_branch;
      logic               exp_local;
      logic [NUM_DDR-1:0] exp_ready;
      stat_req_t          exp_req;
      stat_rsp_t          exp_rsp;
      if (cycle_cnt > 0)
      begin
         exp_branch = sync_rst_n && (rel_edges >= BRANCH_EDGES);
         exp_local  = sync_rst_n && (rel_edges >= SYNC_EDGES);
         check_val("reset_ddr", exp_branch, ddr_rst_n);
         check_val("reset_core", exp_branch, core_rst_n);

         // Odd run length means a done pulse this cycle
         check_val("flr_done", flr_run_prev % 2, flr_done);

         exp_ready[DDR_A_BIT] = ctrl_ready[0];
         exp_ready[DDR_B_BIT] = ctrl_ready[1];
         exp_ready[DDR_C_BIT] = c_ready_prev;
         exp_ready[DDR_D_BIT] = ctrl_ready[2];
         check_val("ready_vec", exp_ready, ddr_ready);

         for (int ch = 0; ch < NUM_STAT_CH; ch++)
         begin
            exp_req = '0;                 // Pipes empty while held in reset
            exp_rsp = '0;
            if (exp_local)
            begin
               exp_req = req_hist[ch][STAT_PIPE_STAGES-1];
               exp_rsp = rsp_hist[ch][STAT_PIPE_STAGES-1];
            end
            check_val($sformatf("stat_req_ch%0d", ch), exp_req, stat_req_out[ch]);
            check_val($sformatf("stat_rsp_ch%0d", ch), exp_rsp, stat_rsp_out[ch]);
            if (!exp_branch)
            begin
               check_val("req_strobe_in_reset", 0,
                         stat_req_out[ch].wr | stat_req_out[ch].rd);
               check_val("rsp_ack_in_reset", 0, stat_rsp_out[ch].ack);
            end
         end

         check_val("core_awid", CORE_ID_W'(host_awid), core_awid);
         check_val("core_arid", CORE_ID_W'(host_arid), core_arid);
         check_val("host_bid", core_bid[HOST_ID_W-1:0], host_bid);
         check_val("host_rid", core_rid[HOST_ID_W-1:0], host_rid);
      end
   end

   // ------------------------------------------------------------------------
   // Test sequence

   initial
   begin
      lfsr_state   = 16'd55533;
      cycle_cnt    = 0;
      check_cnt    = 0;
      err_cnt      = 0;
      rel_edges    = 0;
      flr_run      = 0;
      flr_run_prev = 0;
      c_ready_prev = 1'b0;
      sync_rst_n   = 1'b0;
      flr_assert   = 1'b0;
      ctrl_ready   = '0;
      ddr_c_ready  = 1'b0;
      host_awid    = '0;
      host_arid    = '0;
      core_bid     = '0;
      core_rid     = '0;
      for (int ch = 0; ch < NUM_STAT_CH; ch++)
      begin
         stat_req_in[ch] = '0;
         stat_rsp_in[ch] = '0;
         for (int i = 0; i < STAT_PIPE_STAGES; i++)
         begin
            req_hist[ch][i] = '0;
            rsp_hist[ch][i] = '0;
         end
      end

      // Power-on reset and release
      repeat (RESET_CYCLES) @(posedge clk_main_a0);
      sync_rst_n <= 1'b1;
      repeat (BRANCH_EDGES + 2) @(posedge clk_main_a0);

      // FLR held long, then single and double cycle requests
      flr_assert <= 1'b1;
      repeat (9) @(posedge clk_main_a0);
      flr_assert <= 1'b0;
      repeat (5) @(posedge clk_main_a0);
      flr_assert <= 1'b1;
      @(posedge clk_main_a0);
      flr_assert <= 1'b0;
      repeat (5) @(posedge clk_main_a0);
      flr_assert <= 1'b1;
      repeat (2) @(posedge clk_main_a0);
      flr_assert <= 1'b0;
      repeat (5) @(posedge clk_main_a0);

      // Back-to-back traffic on all channels
      repeat (300)
      begin
         drive_random();
         @(posedge clk_main_a0);
      end

      // Reset pulse lands with random traffic still in the pipes
      drive_idle();
      @(posedge clk_main_a0);
      sync_rst_n <= 1'b0;
      repeat (3) @(posedge clk_main_a0);
      sync_rst_n <= 1'b1;
      repeat (BRANCH_EDGES + 2) @(posedge clk_main_a0);

      // Traffic again after the second release
      repeat (40)
      begin
         drive_random();
         @(posedge clk_main_a0);
      end
      drive_idle();
      repeat (STAT_PIPE_STAGES + 2) @(posedge clk_main_a0);

      $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- vlog.f
shell_glue_pkg.sv
lib_pipe.sv
rst_sync_tree.sv
flr_ready_monitor.sv
ddr_stat_bridge.sv
cl_shell_top.sv
tb_cl_shell_top.sv
